//--- Makefile
# Verilator build and run of the falling block engine testbench
# override any variable on the command line, e.g. make sim LOG=run.log

VERILATOR ?= verilator
TOP       ?= tetris_tb
FLIST     ?= tetris.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -Wno-fatal -j 0

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FLIST) --Mdir $(OBJ_DIR) -o V$(TOP)
	./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1; status=$$?; cat $(LOG); \
	if [ $$status -ne 0 ] || grep -q "Test FAILED" $(LOG); then \
	  echo "simulation failed, see $(LOG)"; exit 1; \
	fi

clean:
	rm -rf $(OBJ_DIR) $(LOG)

//--- source/cand_if.sv
`timescale 1ns/1ps
`default_nettype none

// candidate placement, controller -> shaper -> playfield -> controller
interface cand_if;
  import tetris_pkg::*;

  piece_t kind;
  rot_t   rot;
  row_t   org_row;
  col_t   org_col;

  row_t   cell_row [4];  // absolute cell positions
  col_t   cell_col [4];
  color_t color;
  logic   oob;           // some cell off the field

  logic   hit;

  modport ctrl  (output kind, rot, org_row, org_col, input hit);

  modport shape (input kind, rot, org_row, org_col,
                 output cell_row, cell_col, color, oob);

  modport field (input cell_row, cell_col, color, oob, output hit);

endinterface

`default_nettype wire

//--- source/piece_shaper.sv
`timescale 1ns/1ps
`default_nettype none
`include "tetris_settings.svh"

module piece_shaper (
  cand_if.shape sh
);
  import tetris_pkg::*;

  logic [15:0] shape_bits;  // four (row,col) pairs, 2 bits each
  logic [1:0]  span;        // rotation pivot, 3 for I else 2
  logic [1:0]  off_r [4];
  logic [1:0]  off_c [4];

  ////////////////////////////////////////////////////////////
  // rotation 0 offsets
  ////////////////////////////////////////////////////////////
  always_comb begin
    case (sh.kind)
      PC_I:    shape_bits = {2'd1, 2'd0, 2'd1, 2'd1, 2'd1, 2'd2, 2'd1, 2'd3};
      PC_O:    shape_bits = {2'd0, 2'd1, 2'd0, 2'd2, 2'd1, 2'd1, 2'd1, 2'd2};
      PC_T:    shape_bits = {2'd0, 2'd1, 2'd1, 2'd0, 2'd1, 2'd1, 2'd1, 2'd2};
      PC_S:    shape_bits = {2'd0, 2'd1, 2'd0, 2'd2, 2'd1, 2'd0, 2'd1, 2'd1};
      PC_Z:    shape_bits = {2'd0, 2'd0, 2'd0, 2'd1, 2'd1, 2'd1, 2'd1, 2'd2};
      PC_J:    shape_bits = {2'd0, 2'd0, 2'd1, 2'd0, 2'd1, 2'd1, 2'd1, 2'd2};
      PC_L:    shape_bits = {2'd0, 2'd2, 2'd1, 2'd0, 2'd1, 2'd1, 2'd1, 2'd2};
      default: shape_bits = '0;
    endcase
  end

  assign span = (sh.kind == PC_I) ? 2'd3 : 2'd2;

  ////////////////////////////////////////////////////////////
  // rotation, one clockwise turn per step
  ////////////////////////////////////////////////////////////
  always_comb begin
    logic [1:0] tmp;
    tmp = '0;
    for (int i = 0; i < 4; i++) begin
      off_r[i] = shape_bits[15-4*i -: 2];
      off_c[i] = shape_bits[13-4*i -: 2];
      if (sh.kind != PC_O) begin  // O is symmetric
        for (int j = 0; j < 3; j++) begin
          if (j < sh.rot) begin
            tmp      = off_r[i];
            off_r[i] = off_c[i];      // (r,c) -> (c, span-r)
            off_c[i] = span - tmp;
          end
        end
      end
    end
  end

  ////////////////////////////////////////////////////////////
  // absolute cells and bounds test
  ////////////////////////////////////////////////////////////
  always_comb begin
    sh.oob = 1'b0;
    for (int i = 0; i < 4; i++) begin
      sh.cell_row[i] = sh.org_row + row_t'(off_r[i]);
      sh.cell_col[i] = sh.org_col + col_t'(off_c[i]);
      if (sh.cell_col[i] < 0 || sh.cell_col[i] >= `TET_COLS) begin
        sh.oob = 1'b1;
      end
      if (sh.cell_row[i] >= `TET_ROWS) begin
        sh.oob = 1'b1;  // below the floor
      end
    end
  end

  assign sh.color = color_t'(sh.kind) + color_t'(1);  // kind k -> colour k+1

endmodule

`default_nettype wire

//--- source/playfield.sv
`timescale 1ns/1ps
`default_nettype none
`include "tetris_settings.svh"

module playfield (
  input  logic                clk,
  input  logic                rst,
  cand_if.field               fld,
  input  logic                lock_i,
  input  logic                clear_en_i,
  input  logic                clear_all_i,
  output logic                row_full_o,
  output logic                top_busy_o,
  input  tetris_pkg::row_t    rd_row_i,
  input  tetris_pkg::col_t    rd_col_i,
  output tetris_pkg::color_t  rd_color_o
);
  import tetris_pkg::*;

  color_t grid [`TET_ROWS][`TET_COLS];  // row 0 at the top

  logic [`TET_ROWS-1:0] full;
  logic [4:0]           low_row;   // lowest full row
  logic [3:0]           occ;       // candidate cell already taken

  // colour at (r,c), empty outside the field
  function automatic color_t cell_at(input row_t r, input col_t c);
    if (r < 0 || r >= `TET_ROWS || c < 0 || c >= `TET_COLS) begin
      return '0;
    end
    return grid[r[4:0]][c[3:0]];
  endfunction

  ////////////////////////////////////////////////////////////
  // collision test
  ////////////////////////////////////////////////////////////
  always_comb begin
    for (int i = 0; i < 4; i++) begin
      occ[i] = (cell_at(fld.cell_row[i], fld.cell_col[i]) != '0);
    end
    fld.hit = fld.oob | (|occ);
  end

  ////////////////////////////////////////////////////////////
  // full rows and top row
  ////////////////////////////////////////////////////////////
  always_comb begin
    low_row    = '0;
    top_busy_o = 1'b0;
    for (int r = 0; r < `TET_ROWS; r++) begin
      full[r] = 1'b1;
      for (int c = 0; c < `TET_COLS; c++) begin
        if (grid[r][c] == '0) full[r] = 1'b0;
      end
      if (full[r]) low_row = 5'(r);  // last match is the lowest
    end
    for (int c = 0; c < `TET_COLS; c++) begin
      if (grid[0][c] != '0) top_busy_o = 1'b1;
    end
  end

  assign row_full_o = |full;

  ////////////////////////////////////////////////////////////
  // grid update
  ////////////////////////////////////////////////////////////
  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      for (int r = 0; r < `TET_ROWS; r++) begin
        for (int c = 0; c < `TET_COLS; c++) grid[r][c] <= '0;
      end
    end else if (clear_all_i) begin
      for (int r = 0; r < `TET_ROWS; r++) begin
        for (int c = 0; c < `TET_COLS; c++) grid[r][c] <= '0;
      end
    end else if (lock_i) begin
      if (!fld.oob) begin
        for (int i = 0; i < 4; i++) begin
          grid[fld.cell_row[i][4:0]][fld.cell_col[i][3:0]] <= fld.color;
        end
      end
    end else if (clear_en_i && row_full_o) begin
      // drop everything above the cleared row by one
      for (int r = 1; r < `TET_ROWS; r++) begin
        if (r <= low_row) grid[r] <= grid[r-1];
      end
      for (int c = 0; c < `TET_COLS; c++) grid[0][c] <= '0;
    end
  end

  // read port, registered field only
  always_comb begin
    rd_color_o = cell_at(rd_row_i, rd_col_i);
  end

endmodule

`default_nettype wire

//--- source/tetris_fsm.sv
`timescale 1ns/1ps
`default_nettype none
`include "tetris_settings.svh"

module tetris_fsm (
  input  logic                     clk,
  input  logic                     rst,
  input  logic                     start_i,
  input  logic                     step_i,
  input  logic                     right_i,
  input  logic                     left_i,
  input  logic                     rr_i,
  input  logic                     rl_i,
  cand_if.ctrl                     cand,
  input  logic                     row_full_i,
  input  logic                     top_busy_i,
  output logic                     lock_o,
  output logic                     clear_en_o,
  output logic                     clear_all_o,
  output tetris_pkg::state_t       state_o,
  output tetris_pkg::piece_t       piece_o,
  output tetris_pkg::rot_t         rot_o,
  output tetris_pkg::row_t         row_o,
  output tetris_pkg::col_t         col_o,
  output logic [`TET_LINES_W-1:0]  lines_o
);
  import tetris_pkg::*;

  state_t state, state_nx;
  move_t  move;
  piece_t kind;        // active piece
  piece_t next_kind;   // next to spawn
  rot_t   rot;
  row_t   row;
  col_t   col;
  logic   load;        // candidate becomes the active piece
  logic [`TET_LINES_W-1:0] lines;

  ////////////////////////////////////////////////////////////
  // move select and candidate
  ////////////////////////////////////////////////////////////
  always_comb begin
    move = MV_NONE;
    if (state == ST_ACTIVE && step_i) begin
      if (right_i)     move = MV_RIGHT;
      else if (left_i) move = MV_LEFT;
      else if (rr_i)   move = MV_ROR;
      else if (rl_i)   move = MV_ROL;
      else             move = MV_DOWN;  // gravity by default
    end
  end

  always_comb begin
    cand.kind    = kind;
    cand.rot     = rot;
    cand.org_row = row;
    cand.org_col = col;
    if (state == ST_SPAWN) begin
      cand.kind    = next_kind;
      cand.rot     = '0;
      cand.org_row = '0;
      cand.org_col = col_t'(`TET_SPAWN_COL);
    end else begin
      case (move)
        MV_DOWN:  cand.org_row = row + row_t'(1);
        MV_RIGHT: cand.org_col = col + col_t'(1);
        MV_LEFT:  cand.org_col = col - col_t'(1);
        MV_ROR:   cand.rot     = rot + rot_t'(1);  // wraps mod 4
        MV_ROL:   cand.rot     = rot - rot_t'(1);
        default:  ;
      endcase
    end
  end

  assign load = ((state == ST_SPAWN) || (move != MV_NONE)) && !cand.hit;

  ////////////////////////////////////////////////////////////
  // next state
  ////////////////////////////////////////////////////////////
  always_comb begin
    state_nx = state;
    case (state)
      ST_IDLE:      if (start_i) state_nx = ST_SPAWN;
      ST_SPAWN:     state_nx = cand.hit ? ST_GAME_OVER : ST_ACTIVE;
      ST_ACTIVE:    if (move == MV_DOWN && cand.hit) state_nx = ST_LOCK;
      ST_LOCK:      state_nx = ST_CLEAR;
      ST_CLEAR: begin
        if (!row_full_i) state_nx = top_busy_i ? ST_GAME_OVER : ST_SPAWN;
      end
      ST_GAME_OVER: if (start_i) state_nx = ST_IDLE;
      default:      state_nx = ST_IDLE;
    endcase
  end

  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      state     <= ST_IDLE;
      kind      <= PC_I;
      next_kind <= PC_I;
      rot       <= '0;
      row       <= '0;
      col       <= col_t'(`TET_SPAWN_COL);
    end else begin
      state <= state_nx;
      if (load) begin
        kind <= cand.kind;
        rot  <= cand.rot;
        row  <= cand.org_row;
        col  <= cand.org_col;
      end
      // sequence moves on only after a successful spawn
      if (state == ST_SPAWN && !cand.hit) begin
        next_kind <= (next_kind == PC_L) ? PC_I : piece_t'(next_kind + 3'd1);
      end
    end
  end

  ////////////////////////////////////////////////////////////
  // line counter
  ////////////////////////////////////////////////////////////
  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      lines <= '0;
    end else if (clear_all_o) begin
      lines <= '0;  // new game
    end else if (state == ST_CLEAR && row_full_i && lines != '1) begin
      lines <= lines + 1'b1;  // saturates
    end
  end

  assign lock_o      = (state == ST_LOCK);
  assign clear_en_o  = (state == ST_CLEAR);
  assign clear_all_o = (state == ST_GAME_OVER) && start_i;

  assign state_o = state;
  assign piece_o = kind;
  assign rot_o   = rot;
  assign row_o   = row;
  assign col_o   = col;
  assign lines_o = lines;

endmodule

`default_nettype wire

//--- source/tetris_pkg.sv
`default_nettype none

package tetris_pkg;

  // game controller states
  typedef enum logic [2:0] {
    ST_IDLE,
    ST_SPAWN,
    ST_ACTIVE,
    ST_LOCK,
    ST_CLEAR,
    ST_GAME_OVER
  } state_t;

  typedef enum logic [2:0] {
    MV_NONE,
    MV_DOWN,
    MV_RIGHT,
    MV_LEFT,
    MV_ROR,   // quarter turn clockwise
    MV_ROL    // quarter turn counter clockwise
  } move_t;

  // spawn order follows the encoding
  typedef enum logic [2:0] {
    PC_I = 3'd0,
    PC_O = 3'd1,
    PC_T = 3'd2,
    PC_S = 3'd3,
    PC_Z = 3'd4,
    PC_J = 3'd5,
    PC_L = 3'd6
  } piece_t;

  typedef logic [2:0]        color_t;  // 0 is an empty cell
  typedef logic signed [5:0] row_t;
  typedef logic signed [4:0] col_t;    // negative for left of the wall
  typedef logic [1:0]        rot_t;

endpackage

`default_nettype wire

//--- source/tetris_settings.svh
`ifndef TETRIS_SETTINGS_SVH
`define TETRIS_SETTINGS_SVH

// playfield geometry
`define TET_ROWS 21
`define TET_COLS 10

// origin column of a freshly spawned piece
`define TET_SPAWN_COL 3

// cleared line counter, saturating
`define TET_LINES_W 8

`endif

//--- source/tetris_top.sv
`timescale 1ns/1ps
`default_nettype none
`include "tetris_settings.svh"

module tetris_top (
  input  logic                     clk,
  input  logic                     rst,
  input  logic                     start_i,
  input  logic                     step_i,   // one move per strobe
  input  logic                     right_i,
  input  logic                     left_i,
  input  logic                     rr_i,
  input  logic                     rl_i,
  input  tetris_pkg::row_t         rd_row_i,
  input  tetris_pkg::col_t         rd_col_i,
  output tetris_pkg::state_t       state_o,
  output tetris_pkg::piece_t       piece_o,
  output tetris_pkg::rot_t         rot_o,
  output tetris_pkg::row_t         row_o,
  output tetris_pkg::col_t         col_o,
  output logic [`TET_LINES_W-1:0]  lines_o,
  output tetris_pkg::color_t       rd_color_o
);

  logic lock, clear_en, clear_all;
  logic row_full, top_busy;

  cand_if u_cand ();

  ////////////////////////////////////////////////////////////
  // controller, shaper, field
  ////////////////////////////////////////////////////////////
  tetris_fsm u_fsm (
    .clk, .rst, .start_i, .step_i, .right_i, .left_i, .rr_i, .rl_i,
    .cand        (u_cand.ctrl),
    .row_full_i  (row_full),
    .top_busy_i  (top_busy),
    .lock_o      (lock),
    .clear_en_o  (clear_en),
    .clear_all_o (clear_all),
    .state_o, .piece_o, .rot_o, .row_o, .col_o, .lines_o
  );

  piece_shaper u_shaper (
    .sh (u_cand.shape)
  );

  playfield u_field (
    .clk, .rst,
    .fld         (u_cand.field),
    .lock_i      (lock),
    .clear_en_i  (clear_en),
    .clear_all_i (clear_all),
    .row_full_o  (row_full),
    .top_busy_o  (top_busy),
    .rd_row_i, .rd_col_i, .rd_color_o
  );

endmodule

`default_nettype wire

//--- test/tetris_asserts.sv
`timescale 1ns/1ps
`default_nettype none
`include "tetris_settings.svh"

module tetris_asserts (
  input logic                     clk,
  input logic                     rst,
  input tetris_pkg::state_t       state_i,
  input logic                     lock_i,
  input logic                     clear_en_i,
  input logic [`TET_LINES_W-1:0]  lines_i
);
  import tetris_pkg::*;

  // lock pulse comes straight out of the active phase
  a_lock_after_active: assert property (@(posedge clk) disable iff (rst)
    lock_i |-> ($past(state_i) == ST_ACTIVE))
    else $error("lock pulse without a preceding active state");

  // clearing starts on the cycle after the lock pulse
  a_clear_after_lock: assert property (@(posedge clk) disable iff (rst)
    $rose(clear_en_i) |-> $past(lock_i))
    else $error("clear enable rose without a lock pulse before it");

  // only a restart from game over may drop the count
  a_lines_monotonic: assert property (@(posedge clk) disable iff (rst)
    (lines_i < $past(lines_i)) |-> ($past(state_i) == ST_GAME_OVER))
    else $error("line count decreased during a game");

  a_state_known: assert property (@(posedge clk) disable iff (rst)
    !$isunknown(state_i))
    else $error("controller state is unknown");

endmodule

bind tetris_fsm tetris_asserts u_asserts (
  .clk        (clk),
  .rst        (rst),
  .state_i    (state_o),
  .lock_i     (lock_o),
  .clear_en_i (clear_en_o),
  .lines_i    (lines_o)
);

`default_nettype wire

//--- test/tetris_stim.txt
# cmd args: T name | S | M move steps | C state | P kind rot row col | X row col colour | N lines | E
# moves D down R right L left C clockwise A anticlockwise, states 0 idle 2 active 5 game over
T reset
C 0
N 0
E
S
C 2
P 0 0 0 3
T sideways
M R 5
P 0 0 0 6
M L 8
P 0 0 0 0
T rotate
M C 1
P 0 1 0 0
M A 1
P 0 0 0 0
M A 1
P 0 3 0 0
M C 2
P 0 1 0 0
M R 9
P 0 1 0 7
M C 1
P 0 1 0 7
T drop_lock
M D 18
C 2
P 1 0 0 3
X 17 9 1
X 20 9 1
X 16 9 0
X 20 8 0
T line_clear
M L 4
M D 20
C 2
P 2 0 0 3
M L 1
M D 20
C 2
M L 3
M D 18
C 2
M L 1
M D 17
C 2
M L 3
M D 15
C 2
M L 1
M D 14
C 2
P 0 0 0 3
M R 2
M D 20
C 2
N 1
P 1 0 0 3
X 20 0 2
X 20 2 0
X 20 3 3
X 20 5 0
X 20 9 1
X 19 0 4
X 18 4 5
X 17 9 0
X 16 2 6
X 14 4 7
T game_over
M D 1000
C 5
N 1
S
C 0
N 0
E
S
C 2

//--- test/tetris_tb.sv
`timescale 1ns/1ps
`default_nettype none
`include "tetris_settings.svh"

module tetris_tb;
  import tetris_pkg::*;

  localparam int WAIT_LIMIT = 100;  // cycles allowed to reach a state

  logic   clk;
  logic   rst;
  logic   start_i;
  logic   step_i;
  logic   right_i;
  logic   left_i;
  logic   rr_i;
  logic   rl_i;
  row_t   rd_row_i;
  col_t   rd_col_i;
  state_t state_o;
  piece_t piece_o;
  rot_t   rot_o;
  row_t   row_o;
  col_t   col_o;
  color_t rd_color_o;
  logic [`TET_LINES_W-1:0] lines_o;

  string test_name;
  int    test_errs;
  int    tests;
  int    failed_tests;
  int    checks;
  int    errs;

  tetris_top u_tetris_top (
    .clk, .rst, .start_i, .step_i, .right_i, .left_i, .rr_i, .rl_i,
    .rd_row_i, .rd_col_i,
    .state_o, .piece_o, .rot_o, .row_o, .col_o, .lines_o, .rd_color_o
  );

  initial begin
    clk = 1'b0;
    forever #4 clk = ~clk;
  end

  ////////////////////////////////////////////////////////////
  // checking and bookkeeping
  ////////////////////////////////////////////////////////////
  task automatic expect_value(input string what, input int exp_v, input int act_v);
    checks++;
    assert (act_v == exp_v) else begin
      $display("[FAIL] %s %s: expected %0d, actual %0d", test_name, what, exp_v, act_v);
      errs++;
      test_errs++;
    end
  endtask

  task automatic close_test();
    if (test_name != "") begin
      tests++;
      if (test_errs == 0) begin
        $display("%-12s passed", test_name);
      end else begin
        $display("%-12s failed with %0d errors", test_name, test_errs);
        failed_tests++;
      end
    end
    test_errs = 0;
  endtask

  ////////////////////////////////////////////////////////////
  // stimulus, all driven on the falling edge
  ////////////////////////////////////////////////////////////
  task automatic pulse_start();
    @(negedge clk);
    start_i = 1'b1;
    @(negedge clk);
    start_i = 1'b0;
  endtask

  // step strobe held for one cycle per move
  task automatic run_moves(input byte mv, input int steps);
    if (mv != "D" && mv != "R" && mv != "L" && mv != "C" && mv != "A") begin
      $display("%s: unknown move letter %c in the command file", test_name, mv);
      errs++;
      test_errs++;
      return;
    end
    for (int i = 0; i < steps; i++) begin
      @(negedge clk);
      step_i  = 1'b1;
      right_i = (mv == "R");
      left_i  = (mv == "L");
      rr_i    = (mv == "C");
      rl_i    = (mv == "A");
    end
    @(negedge clk);
    step_i  = 1'b0;
    right_i = 1'b0;
    left_i  = 1'b0;
    rr_i    = 1'b0;
    rl_i    = 1'b0;
  endtask

  task automatic wait_for_state(input int exp_st);
    int cnt;
    cnt = 0;
    while (int'(state_o) != exp_st && cnt < WAIT_LIMIT) begin
      @(negedge clk);
      cnt++;
    end
    if (int'(state_o) != exp_st) begin
      $display("%s: timed out after %0d cycles waiting for state %0d, state is %0d",
               test_name, WAIT_LIMIT, exp_st, int'(state_o));
    end
    expect_value("state", exp_st, int'(state_o));
  endtask

  task automatic read_cell(input int r, input int c, output int color);
    @(negedge clk);
    rd_row_i = row_t'(r);
    rd_col_i = col_t'(c);
    #1;  // read port settles
    color = int'(rd_color_o);
  endtask

  task automatic check_field_empty();
    int bad;
    int color;
    bad = 0;
    for (int r = 0; r < `TET_ROWS; r++) begin
      for (int c = 0; c < `TET_COLS; c++) begin
        read_cell(r, c, color);
        if (color != 0) bad++;
      end
    end
    expect_value("occupied cells", 0, bad);
  endtask

  ////////////////////////////////////////////////////////////
  // command file interpreter
  ////////////////////////////////////////////////////////////
  initial begin
    int    fd;
    int    a;
    int    b;
    int    c;
    int    d;
    int    color;
    byte   cmd;
    byte   mv;
    string line;
    string name;

    rst      = 1'b1;
    start_i  = 1'b0;
    step_i   = 1'b0;
    right_i  = 1'b0;
    left_i   = 1'b0;
    rr_i     = 1'b0;
    rl_i     = 1'b0;
    rd_row_i = '0;
    rd_col_i = '0;
    test_name    = "";
    test_errs    = 0;
    tests        = 0;
    failed_tests = 0;
    checks       = 0;
    errs         = 0;

    repeat (10) @(posedge clk);
    @(negedge clk);
    rst = 1'b0;

    fd = $fopen("test/tetris_stim.txt", "r");
    if (fd == 0) begin
      $display("could not open the command file test/tetris_stim.txt");
      errs++;
    end else begin
      while (!$feof(fd)) begin
        line = "";
        cmd  = " ";
        void'($fgets(line, fd));
        void'($sscanf(line, "%c", cmd));
        case (cmd)
          "T": begin
            close_test();
            void'($sscanf(line, "%c %s", cmd, name));
            test_name = name;
          end
          "S": pulse_start();
          "M": begin
            void'($sscanf(line, "%c %c %d", cmd, mv, a));
            run_moves(mv, a);
          end
          "C": begin
            void'($sscanf(line, "%c %d", cmd, a));
            wait_for_state(a);
          end
          "P": begin
            void'($sscanf(line, "%c %d %d %d %d", cmd, a, b, c, d));
            expect_value("kind", a, int'(piece_o));
            expect_value("rot", b, int'(rot_o));
            expect_value("row", c, int'(row_o));
            expect_value("col", d, int'(col_o));
          end
          "X": begin
            void'($sscanf(line, "%c %d %d %d", cmd, a, b, c));
            read_cell(a, b, color);
            expect_value($sformatf("cell(%0d,%0d)", a, b), c, color);
          end
          "N": begin
            void'($sscanf(line, "%c %d", cmd, a));
            expect_value("lines", a, int'(lines_o));
          end
          "E": check_field_empty();
          default: ;  // comment or blank line
        endcase
      end
      $fclose(fd);
    end

    close_test();
    $display("tests %0d, failed %0d, checks %0d, errors %0d",
             tests, failed_tests, checks, errs);
    if (errs == 0) begin
      $display("Test OK");
    end else begin
      $display("Test FAILED");
    end
    $finish;
  end

endmodule

`default_nettype wire

//--- tetris.f
+incdir+source
source/tetris_pkg.sv
source/cand_if.sv
source/piece_shaper.sv
source/playfield.sv
source/tetris_fsm.sv
source/tetris_top.sv
test/tetris_asserts.sv
test/tetris_tb.sv
